/* gate_pkg.sv */
package gate_pkg;

	// One byte of the host stream, in either direction
	typedef logic [7:0] byte_t;

	// Local bus address, only the low bits reach the register bank
	typedef logic [23:0] lb_addr_t;

	// Local bus data word, both directions
	typedef logic [31:0] lb_data_t;

	// Control byte followed by the 24-bit address
	// First half of every transaction, sent back in the reply
	typedef logic [31:0] ctl_word_t;

	// Cycles from lb_strobe until lb_din carries the read data
	localparam int READ_DELAY = 3;

	// Address bits decoded by the register bank
	localparam int REG_ADDR_W = 4;

	// Read flag inside ctl_word_t, bit 4 of the control byte
	localparam int RD_BIT = 28;

	// Transmit FIFO, 32 entries
	localparam int TX_FIFO_AW = 5;

	// Control words in flight through the read pipeline
	localparam int CTL_FIFO_AW = 2;

endpackage

/* sync_fifo.sv */
module sync_fifo #(
	parameter int dw = 8,
	parameter int aw = 4
) (
	input  logic          clk,
	input  logic          arst_n,
	input  logic [dw-1:0] din,
	input  logic          we,
	input  logic          re,
	output logic [dw-1:0] dout,
	output logic          full,
	output logic          empty
);

	// Storage, no reset needed
	logic [dw-1:0] mem [2**aw];

	// Pointers wrap naturally at the address width
	logic [aw-1:0] wr_ptr;
	logic [aw-1:0] rd_ptr;

	// One extra bit so a full buffer is told apart from an empty one
	logic [aw:0] count;

	logic do_wr;
	logic do_rd;

	// Writes into a full buffer and reads from an empty one are dropped
	assign do_wr = we & ~full;
	assign do_rd = re & ~empty;

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// Simultaneous push and pop leave the count alone
			if (do_wr && !do_rd) begin
				count <= count + 1'b1;
			end else if (do_rd && !do_wr) begin
				count <= count - 1'b1;
			end
		end
	end

	// Fall-through output, head word visible without a read
	assign dout  = mem[rd_ptr];
	assign empty = (count == '0);
	assign full  = (count == (aw + 1)'(2**aw));

endmodule

/* rx_parser.sv */
module rx_parser (
	input  logic                 clk,
	input  logic                 arst_n,
	input  gate_pkg::byte_t      rx_din,
	input  logic                 rx_stb,
	input  logic                 rx_end,
	output gate_pkg::byte_t      echo_byte,
	output logic                 echo_we,
	output logic                 lb_strobe,
	output logic                 lb_rd,
	output logic                 rx_active,
	output gate_pkg::lb_addr_t   lb_addr,
	output gate_pkg::lb_data_t   lb_dout,
	output gate_pkg::ctl_word_t  ctl_word
);

	// Position inside the current 8-byte group
	logic [2:0] cnt8;

	// Set once all 8 nonce bytes have gone by
	logic past_nonce;

	// Last 8 bytes received, oldest at the top
	logic [63:0] rx_sr;

	// Shift register contents after this cycle's byte
	logic [63:0] sr_next;

	// Control and address half of the group that completes now
	gate_pkg::ctl_word_t ctl_next;

	// 8th byte of a transaction arriving this cycle
	logic xact_done;

	assign sr_next   = {rx_sr[55:0], rx_din};
	assign ctl_next  = sr_next[63:32];
	assign xact_done = rx_stb & (&cnt8) & past_nonce;

	// Nonce bytes go straight to the transmit queue
	assign echo_byte = rx_din;
	assign echo_we   = rx_stb & ~past_nonce;

	// In the strobe cycle the register holds the whole transaction
	assign ctl_word = rx_sr[63:32];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cnt8       <= '0;
			past_nonce <= 1'b0;
			rx_sr      <= '0;
			rx_active  <= 1'b0;
			lb_strobe  <= 1'b0;
			lb_rd      <= 1'b0;
			lb_addr    <= '0;
			lb_dout    <= '0;
		end else begin
			// One request per transaction, a cycle after its last byte
			lb_strobe <= xact_done;

			if (rx_stb) begin
				cnt8      <= cnt8 + 1'b1;
				rx_sr     <= sr_next;
				rx_active <= 1'b1;
				if (&cnt8) begin
					past_nonce <= 1'b1;
				end
			end

			// Bus fields change only with a new strobe
			if (xact_done) begin
				lb_rd   <= ctl_next[gate_pkg::RD_BIT];
				lb_addr <= ctl_next[23:0];
				lb_dout <= sr_next[31:0];
			end

			// End of packet wins over a byte in the same cycle
			if (rx_end) begin
				cnt8       <= '0;
				past_nonce <= 1'b0;
				rx_active  <= 1'b0;
			end
		end
	end

endmodule

/* reg_bank.sv */
module reg_bank (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               lb_strobe,
	input  logic               lb_rd,
	input  gate_pkg::lb_addr_t lb_addr,
	input  gate_pkg::lb_data_t lb_dout,
	output gate_pkg::lb_data_t lb_din
);

	// Register file, upper address bits ignored
	gate_pkg::lb_data_t regs [2**gate_pkg::REG_ADDR_W];

	// Read data pipeline, stage 0 loads on the strobe
	gate_pkg::lb_data_t rd_pipe [gate_pkg::READ_DELAY];

	logic [gate_pkg::REG_ADDR_W-1:0] idx;

	assign idx = lb_addr[gate_pkg::REG_ADDR_W-1:0];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 2**gate_pkg::REG_ADDR_W; i++) begin
				regs[i] <= '0;
			end
			for (int i = 0; i < gate_pkg::READ_DELAY; i++) begin
				rd_pipe[i] <= '0;
			end
		end else begin
			if (lb_strobe) begin
				// Old contents captured even on a write
				rd_pipe[0] <= regs[idx];
				if (!lb_rd) begin
					regs[idx] <= lb_dout;
				end
			end
			for (int i = 1; i < gate_pkg::READ_DELAY; i++) begin
				rd_pipe[i] <= rd_pipe[i-1];
			end
		end
	end

	// Valid READ_DELAY cycles after the strobe
	assign lb_din = rd_pipe[gate_pkg::READ_DELAY-1];

endmodule

/* reply_builder.sv */
module reply_builder (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                lb_strobe,
	input  gate_pkg::ctl_word_t ctl_word,
	input  gate_pkg::lb_data_t  lb_din,
	output gate_pkg::byte_t     reply_byte,
	output logic                reply_we,
	output logic                reply_last
);

	// Bit k high k+1 cycles after a strobe
	// Low part covers the read latency, top 8 bits the byte slots
	logic [gate_pkg::READ_DELAY+7:0] stb_pipe;

	// Read data is valid on lb_din this cycle
	logic load;

	// Oldest control word still waiting for its data
	gate_pkg::ctl_word_t ctl_head;

	// Reply being serialized, next byte at the top
	logic [63:0] tx_sr;

	assign load = stb_pipe[gate_pkg::READ_DELAY-1];

	// Holds control words while their reads are in flight
	sync_fifo #(
		.dw ($bits(gate_pkg::ctl_word_t)),
		.aw (gate_pkg::CTL_FIFO_AW)
	) ctl_fifo (
		.clk    (clk),
		.arst_n (arst_n),
		.din    (ctl_word),
		.we     (lb_strobe),
		.re     (load),
		.dout   (ctl_head),
		.full   (),
		.empty  ()
	);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			stb_pipe <= '0;
			tx_sr    <= '0;
		end else begin
			stb_pipe <= {stb_pipe[gate_pkg::READ_DELAY+6:0], lb_strobe};
			// A new load may meet the last byte of the previous reply
			if (load) begin
				tx_sr <= {ctl_head, lb_din};
			end else if (reply_we) begin
				tx_sr <= {tx_sr[55:0], 8'h00};
			end
		end
	end

	// Eight byte slots follow the load cycle
	assign reply_we   = |stb_pipe[gate_pkg::READ_DELAY+7:gate_pkg::READ_DELAY];
	assign reply_last = stb_pipe[gate_pkg::READ_DELAY+7];
	assign reply_byte = tx_sr[63:56];

endmodule

/* tx_queue.sv */
module tx_queue (
	input  logic            clk,
	input  logic            arst_n,
	input  gate_pkg::byte_t echo_byte,
	input  gate_pkg::byte_t reply_byte,
	input  logic            echo_we,
	input  logic            reply_we,
	input  logic            reply_last,
	input  logic            lb_strobe,
	input  logic            rx_active,
	input  logic            tx_stb,
	output gate_pkg::byte_t tx_dout,
	output logic            tx_rdy,
	output logic            tx_end
);

	// Byte plus its last-of-reply tag
	logic [$bits(gate_pkg::byte_t):0] fifo_din;
	logic [$bits(gate_pkg::byte_t):0] fifo_dout;

	logic fifo_empty;
	logic fifo_re;
	logic head_last;

	// Transactions issued whose last reply byte is not yet taken
	logic [5:0] pending;

	// Echo bytes never carry the tag
	assign fifo_din = echo_we ? {echo_byte, 1'b0} : {reply_byte, reply_last};

	sync_fifo #(
		.dw ($bits(gate_pkg::byte_t) + 1),
		.aw (gate_pkg::TX_FIFO_AW)
	) tx_fifo (
		.clk    (clk),
		.arst_n (arst_n),
		.din    (fifo_din),
		.we     (echo_we | reply_we),
		.re     (fifo_re),
		.dout   (fifo_dout),
		.full   (),
		.empty  (fifo_empty)
	);

	assign {tx_dout, head_last} = fifo_dout;
	assign tx_rdy  = ~fifo_empty;
	assign fifo_re = tx_rdy & tx_stb;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pending <= '0;
		end else if (lb_strobe && !(fifo_re && head_last)) begin
			pending <= pending + 1'b1;
		end else if (!lb_strobe && fifo_re && head_last) begin
			pending <= pending - 1'b1;
		end
	end

	// Final byte only once the packet is over and nothing else is due
	assign tx_end = tx_rdy & head_last & (pending == 6'd1) & ~rx_active;

endmodule

/* lb_gate.sv */
module lb_gate (
	input  logic               clk,
	input  logic               arst_n,
	// Byte stream from the host
	input  gate_pkg::byte_t    rx_din,
	input  logic               rx_stb,
	input  logic               rx_end,
	// Byte stream back to the host
	output gate_pkg::byte_t    tx_dout,
	output logic               tx_rdy,
	output logic               tx_end,
	input  logic               tx_stb,
	// Local bus, visible at the top
	output gate_pkg::lb_addr_t lb_addr,
	output gate_pkg::lb_data_t lb_dout,
	output logic               lb_rd,
	output logic               lb_strobe
);

	// Nonce loopback
	gate_pkg::byte_t echo_byte;
	logic            echo_we;

	// Header half of the current transaction
	gate_pkg::ctl_word_t ctl_word;
	logic                rx_active;

	// Read data from the register bank
	gate_pkg::lb_data_t lb_din;

	// Serialized reply bytes
	gate_pkg::byte_t reply_byte;
	logic            reply_we;
	logic            reply_last;

	rx_parser u_rx_parser (
		.clk       (clk),
		.arst_n    (arst_n),
		.rx_din    (rx_din),
		.rx_stb    (rx_stb),
		.rx_end    (rx_end),
		.echo_byte (echo_byte),
		.echo_we   (echo_we),
		.lb_strobe (lb_strobe),
		.lb_rd     (lb_rd),
		.rx_active (rx_active),
		.lb_addr   (lb_addr),
		.lb_dout   (lb_dout),
		.ctl_word  (ctl_word)
	);

	reg_bank u_reg_bank (
		.clk       (clk),
		.arst_n    (arst_n),
		.lb_strobe (lb_strobe),
		.lb_rd     (lb_rd),
		.lb_addr   (lb_addr),
		.lb_dout   (lb_dout),
		.lb_din    (lb_din)
	);

	reply_builder u_reply_builder (
		.clk        (clk),
		.arst_n     (arst_n),
		.lb_strobe  (lb_strobe),
		.ctl_word   (ctl_word),
		.lb_din     (lb_din),
		.reply_byte (reply_byte),
		.reply_we   (reply_we),
		.reply_last (reply_last)
	);

	// Echo and reply bytes never overlap in time
	tx_queue u_tx_queue (
		.clk        (clk),
		.arst_n     (arst_n),
		.echo_byte  (echo_byte),
		.reply_byte (reply_byte),
		.echo_we    (echo_we),
		.reply_we   (reply_we),
		.reply_last (reply_last),
		.lb_strobe  (lb_strobe),
		.rx_active  (rx_active),
		.tx_stb     (tx_stb),
		.tx_dout    (tx_dout),
		.tx_rdy     (tx_rdy),
		.tx_end     (tx_end)
	);

endmodule

/* tb_lb_gate.sv */
module tb_lb_gate;
	timeunit 1ns;
	timeprecision 100ps;

	logic               clk;
	logic               arst_n;
	gate_pkg::byte_t    rx_din;
	logic               rx_stb;
	logic               rx_end;
	gate_pkg::byte_t    tx_dout;
	logic               tx_rdy;
	logic               tx_end;
	logic               tx_stb;
	gate_pkg::lb_addr_t lb_addr;
	gate_pkg::lb_data_t lb_dout;
	logic               lb_rd;
	logic               lb_strobe;

	// Marks the 8th byte of a transaction, seen by the bus monitor only
	logic xact_tail;
	logic tail_seen;

	int errors;
	int timeouts;
	logic [15:0] lfsr;

	// Register bank contents as the host should see them
	gate_pkg::lb_data_t model [2**gate_pkg::REG_ADDR_W];

	// Packet under construction and its expected reply
	gate_pkg::byte_t send_q [$];
	logic            tail_q [$];
	gate_pkg::byte_t exp_q [$];
	int              n_xact;

	// Requests expected on the local bus, oldest first
	gate_pkg::lb_addr_t bus_addr_q [$];
	gate_pkg::lb_data_t bus_data_q [$];
	logic               bus_rd_q [$];

	// Bytes taken from the tx side, with tx_end at that moment
	gate_pkg::byte_t got_q [$];
	logic            end_q [$];

	// Bus fields of the latest strobe
	gate_pkg::lb_addr_t held_addr;
	gate_pkg::lb_data_t held_data;
	logic               held_rd;
	logic               have_held;

	// Three-read packet sent twice, once with the tx side stalled
	logic [63:0]        keep_nonce;
	gate_pkg::byte_t    keep_ctl [3];
	gate_pkg::lb_addr_t keep_addr [3];

	lb_gate DUT (.*);

	always #2 clk = ~clk;

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Fail at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	// 16-bit Galois LFSR, taps 16,14,13,11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[62:0], lfsr[0]};
		end
		return v;
	endfunction

	// Random control byte, bit 4 is the read flag
	function automatic gate_pkg::byte_t make_ctl(input logic rd);
		gate_pkg::byte_t c;
		c = gate_pkg::byte_t'(rand_bits(8));
		c[4] = rd;
		return c;
	endfunction

	task automatic add_nonce(input logic [63:0] nonce);
		for (int i = 0; i < 8; i++) begin
			send_q.push_back(nonce[63-8*i -: 8]);
			tail_q.push_back(1'b0);
			exp_q.push_back(nonce[63-8*i -: 8]);
		end
	endtask

	// Reply is the header half followed by the register's old contents
	task automatic add_xact(input gate_pkg::byte_t ctl, input gate_pkg::lb_addr_t addr,
			input gate_pkg::lb_data_t data);
		logic [63:0] word;
		logic [63:0] reply;
		word  = {ctl, addr, data};
		reply = {word[63:32], model[addr[gate_pkg::REG_ADDR_W-1:0]]};
		for (int i = 0; i < 8; i++) begin
			send_q.push_back(word[63-8*i -: 8]);
			tail_q.push_back(i == 7);
			exp_q.push_back(reply[63-8*i -: 8]);
		end
		if (!ctl[4]) begin
			model[addr[gate_pkg::REG_ADDR_W-1:0]] = data;
		end
		bus_addr_q.push_back(addr);
		bus_data_q.push_back(data);
		bus_rd_q.push_back(ctl[4]);
		n_xact++;
	endtask

	// Back-to-back bytes, then a one-cycle rx_end
	task automatic send_packet();
		for (int i = 0; i < send_q.size(); i++) begin
			@(posedge clk);
			rx_stb    <= 1'b1;
			rx_din    <= send_q[i];
			xact_tail <= tail_q[i];
		end
		@(posedge clk);
		rx_stb    <= 1'b0;
		xact_tail <= 1'b0;
		rx_end    <= 1'b1;
		@(posedge clk);
		rx_end <= 1'b0;
	endtask

	task automatic collect_bytes(input int n);
		int waited;
		waited = 0;
		got_q.delete();
		end_q.delete();
		while (got_q.size() < n) begin
			@(negedge clk);
			// Byte is taken at the coming rising edge
			if (tx_rdy && tx_stb) begin
				got_q.push_back(tx_dout);
				end_q.push_back(tx_end);
			end
			waited++;
			if (waited > 600) begin
				timeouts++;
				$display("Timeout: only %0d of %0d reply bytes arrived", got_q.size(), n);
				break;
			end
		end
	endtask

	// Every expected request is popped by the bus monitor
	task automatic wait_strobes();
		int waited;
		waited = 0;
		while (bus_addr_q.size() != 0) begin
			@(negedge clk);
			waited++;
			if (waited > 200) begin
				timeouts++;
				$display("Timeout: %0d bus requests never appeared", bus_addr_q.size());
				break;
			end
		end
	endtask

	task automatic run_packet(input logic hold);
		if (hold) begin
			@(posedge clk);
			tx_stb <= 1'b0;
		end
		fork
			send_packet();
			begin
				if (!hold) begin
					collect_bytes(exp_q.size());
				end
			end
		join
		wait_strobes();
		if (hold) begin
			// Last reply byte lands READ_DELAY+10 cycles after its strobe at most
			repeat (gate_pkg::READ_DELAY + 10) @(posedge clk);
			tx_stb <= 1'b1;
			collect_bytes(exp_q.size());
		end
		check("reply length", 64'(got_q.size()), 64'(exp_q.size()));
		for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
			check("tx_dout", 64'(got_q[i]), 64'(exp_q[i]));
			check("tx_end", 64'(end_q[i]), 64'(n_xact > 0 && i == exp_q.size() - 1));
		end
		// Idle gap between packets, nothing more may come out
		repeat (16) @(posedge clk);
		@(negedge clk);
		check("tx_rdy", 64'(tx_rdy), 64'(0));
		send_q.delete();
		tail_q.delete();
		exp_q.delete();
		n_xact = 0;
	endtask

	task automatic echo_only();
		add_nonce(rand_bits(64));
		run_packet(1'b0);
	endtask

	// Second write shows the first one's data
	task automatic write_reply();
		gate_pkg::lb_addr_t a;
		a = gate_pkg::lb_addr_t'(rand_bits(24));
		add_nonce(rand_bits(64));
		add_xact(make_ctl(1'b0), a, gate_pkg::lb_data_t'(rand_bits(32)));
		add_xact(make_ctl(1'b0), a, gate_pkg::lb_data_t'(rand_bits(32)));
		run_packet(1'b0);
	endtask

	// Reads use fresh upper address bits, so they hit aliases
	task automatic read_back();
		logic [gate_pkg::REG_ADDR_W-1:0] idx [4];
		add_nonce(rand_bits(64));
		for (int k = 0; k < 4; k++) begin
			idx[k] = 4'(rand_bits(4));
			add_xact(make_ctl(1'b0), {20'(rand_bits(20)), idx[k]},
				gate_pkg::lb_data_t'(rand_bits(32)));
		end
		run_packet(1'b0);
		add_nonce(rand_bits(64));
		for (int k = 0; k < 4; k++) begin
			add_xact(make_ctl(1'b1), {20'(rand_bits(20)), idx[k]},
				gate_pkg::lb_data_t'(rand_bits(32)));
		end
		run_packet(1'b0);
	endtask

	task automatic build_kept();
		add_nonce(keep_nonce);
		for (int k = 0; k < 3; k++) begin
			add_xact(keep_ctl[k], keep_addr[k], {keep_addr[k], keep_ctl[k]});
		end
	endtask

	task automatic reply_end();
		keep_nonce = rand_bits(64);
		for (int k = 0; k < 3; k++) begin
			keep_ctl[k]  = make_ctl(1'b1);
			keep_addr[k] = gate_pkg::lb_addr_t'(rand_bits(24));
		end
		build_kept();
		run_packet(1'b0);
	endtask

	// Reads leave the model alone, so the expected bytes match the previous packet
	task automatic held_tx();
		build_kept();
		run_packet(1'b1);
	endtask

	// Bus monitor, one strobe per 8th byte and fields steady in between
	always @(negedge clk) begin
		if (arst_n) begin
			check("lb_strobe", 64'(lb_strobe), 64'(tail_seen));
			if (lb_strobe) begin
				if (bus_addr_q.size() == 0) begin
					errors++;
					$display("lb_strobe at %0d ns with no transaction sent", $time);
				end else begin
					check("lb_addr", 64'(lb_addr), 64'(bus_addr_q.pop_front()));
					check("lb_dout", 64'(lb_dout), 64'(bus_data_q.pop_front()));
					check("lb_rd", 64'(lb_rd), 64'(bus_rd_q.pop_front()));
				end
				held_addr = lb_addr;
				held_data = lb_dout;
				held_rd   = lb_rd;
				have_held = 1'b1;
			end else if (have_held) begin
				check("lb_addr hold", 64'(lb_addr), 64'(held_addr));
				check("lb_dout hold", 64'(lb_dout), 64'(held_data));
				check("lb_rd hold", 64'(lb_rd), 64'(held_rd));
			end
			tail_seen = rx_stb && xact_tail;
		end
	end

	initial begin
		clk       = 1'b0;
		arst_n    = 1'b0;
		rx_din    = '0;
		rx_stb    = 1'b0;
		rx_end    = 1'b0;
		tx_stb    = 1'b0;
		xact_tail = 1'b0;
		tail_seen = 1'b0;
		have_held = 1'b0;
		errors    = 0;
		timeouts  = 0;
		n_xact    = 0;
		lfsr      = 16'd14;
		foreach (model[i]) begin
			model[i] = '0;
		end
		repeat (5) @(posedge clk);
		arst_n <= 1'b1;
		tx_stb <= 1'b1;
		repeat (2) @(posedge clk);
		echo_only();
		write_reply();
		read_back();
		reply_end();
		held_tx();
		$display("Errors: %0d mismatches, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

/* lb_gate.f */
gate_pkg.sv
sync_fifo.sv
rx_parser.sv
reg_bank.sv
reply_builder.sv
tx_queue.sv
lb_gate.sv
tb_lb_gate.sv

/* run_sim.sh */
#!/bin/sh
# Build the gateway testbench with Verilator and run it once

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --top-module tb_lb_gate -f lb_gate.f -o sim_lb_gate > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_lb_gate > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

# The log decides the verdict
if grep -q "Regression failed" "$SIM_LOG"; then
	exit 1
fi
exit 0
